//--- verification/intercom_stimulus.txt
# Columns: name mic_aud(hex, or rnd for a quiet random sample) spk_aud(hex) ptt_en ng_btn
#   effect_btn mute_btn hold_cycles exp_vol_en exp_effect_en exp_current_effect(0..4)

# State after reset
reset_idle       rnd 80 0 0 0 0  4 1 0 0

# Effect selection walk, wraps after SOFT
effect_press_1   rnd 80 0 0 1 0  6 1 0 1
effect_rel_1     rnd 80 0 0 0 0  4 1 0 1
effect_press_2   rnd 80 0 0 1 0  6 1 0 2
effect_rel_2     rnd 80 0 0 0 0  4 1 0 2
effect_hold_3    rnd 80 0 0 1 0 24 1 0 3
effect_rel_3     rnd 80 0 0 0 0  4 1 0 3
effect_press_4   rnd 80 0 0 1 0  6 1 0 4
effect_rel_4     rnd 80 0 0 0 0  4 1 0 4
effect_press_5   rnd 80 0 0 1 0  6 1 0 0
effect_rel_5     rnd 80 0 0 0 0  4 1 0 0
effect_press_6   rnd 80 0 0 1 0  6 1 0 1
effect_rel_6     rnd 80 0 0 0 0  4 1 0 1

# Push-to-talk without the gate
ptt_talk         rnd 80 1 0 0 0  4 0 1 1
ptt_release      rnd 80 0 0 0 0  4 1 0 1

# Mute toggle
mute_press_1     rnd 80 0 0 0 1  6 0 0 1
mute_rel_1       rnd 80 0 0 0 0  4 0 0 1
mute_ptt         rnd 80 1 0 0 0  4 0 1 1
mute_ptt_rel     rnd 80 0 0 0 0  4 0 0 1
mute_press_2     rnd 80 0 0 0 1  6 1 0 1
mute_rel_2       rnd 80 0 0 0 0  4 1 0 1

# Noise gate with hold timer
gate_press       rnd 80 0 1 0 0  6 1 0 1
gate_rel         rnd 80 0 0 0 0  4 1 0 1
gate_idle        rnd 80 0 0 0 0  8 1 0 1
voice_high       c8  80 0 0 0 0  6 0 1 1
quiet_short      80  80 0 0 0 0  8 0 1 1
voice_low        32  80 0 0 0 0  6 0 1 1
quiet_long       80  80 0 0 0 0 24 1 0 1
voice_low_start  32  80 0 0 0 0  6 0 1 1
quiet_end        80  80 0 0 0 0 24 1 0 1

# Speaker priority, also clears the gate
ptt_talk_2       rnd 80 1 0 0 0  4 0 1 1
spk_override     rnd 90 1 0 0 0  6 1 0 1
spk_release      rnd 80 0 0 0 0  4 1 0 1
loud_mic_high    c8  80 0 0 0 0  8 1 0 1
loud_mic_low     32  80 0 0 0 0  8 1 0 1
spk_ptt_listen   rnd 40 1 0 0 0  6 1 0 1
gate_press_spk   rnd 40 0 1 0 0  6 1 0 1
gate_rel_spk     rnd 80 0 0 0 0  4 1 0 1
loud_mic_no_gate c8  80 0 0 0 0  8 1 0 1
final_ptt        rnd 80 1 0 0 0  4 0 1 1
final_release    rnd 80 0 0 0 0  4 1 0 1

//--- vlog.f
logic/intercom_pkg.sv
logic/audio_activity.sv
logic/button_toggles.sv
logic/talk_arbiter.sv
logic/intercom_ctrl.sv
verification/intercom_ctrl_tb.sv

//--- Bender.yml
package:
  name: intercom_ctrl

dependencies: {}

sources:
  - files:
      - logic/intercom_pkg.sv
      - logic/audio_activity.sv
      - logic/button_toggles.sv
      - logic/talk_arbiter.sv
      - logic/intercom_ctrl.sv
  - target: test
    files:
      - verification/intercom_ctrl_tb.sv

//--- verification/intercom_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

module intercom_ctrl_tb
  import intercom_pkg::*;
();

  // One line of the stimulus file
  typedef struct packed {
    logic          mic_rnd;       // Fill mic with a quiet random sample
    audio_sample_t mic;
    audio_sample_t spk;
    logic          ptt;
    logic          ng;
    logic          eff;
    logic          mute;
    logic [15:0]   hold;          // Cycles to keep the inputs
    logic          exp_vol;
    logic          exp_effect_en;
    effect_sel_t   exp_effect;
  } step_t;

  logic          clk;
  logic          rst;
  audio_sample_t mic_aud;
  audio_sample_t spk_aud;
  logic          ptt_en;
  logic          ng_btn;
  logic          effect_btn;
  logic          mute_btn;
  logic          vol_en;
  logic          effect_en;
  effect_sel_t   current_effect;

  step_t       steps[$];
  string       step_names[$];
  int          error_count     = 0;
  int          tests_passed    = 0;
  int          tests_failed    = 0;
  int          watchdog_cycles = 0; // Zero until the stimulus is loaded

  intercom_ctrl UUT (
    .clk            (clk),
    .rst            (rst),
    .mic_aud        (mic_aud),
    .spk_aud        (spk_aud),
    .ptt_en         (ptt_en),
    .ng_btn         (ng_btn),
    .effect_btn     (effect_btn),
    .mute_btn       (mute_btn),
    .vol_en         (vol_en),
    .effect_en      (effect_en),
    .current_effect (current_effect)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  task automatic check_value(input string test_name, input string signal_name,
                             input logic [7:0] expected, input logic [7:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: %s expected %0d, actual %0d",
               test_name, signal_name, expected, actual);
      error_count++;
    end
  endtask

  task automatic load_steps(output bit ok);
    int    fd;
    int    count;
    int    line_no;
    int    mic_val;
    int    spk, ptt, ng, eff, mute, hold, vol, een, effect;
    string line;
    string name;
    string mic_str;
    step_t s;
    ok      = 1'b1;
    line_no = 0;
    fd = $fopen("verification/intercom_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file verification/intercom_stimulus.txt");
      ok = 1'b0;
    end else begin
      while (ok && $fgets(line, fd) != 0) begin
        line_no++;
        if (line.len() > 0 && line[0] != "#") begin
          count = $sscanf(line, "%s %s %h %d %d %d %d %d %d %d %d", name, mic_str, spk,
                          ptt, ng, eff, mute, hold, vol, een, effect);
          if (count > 0) begin // Blank lines give no fields
            if (count != 11 || hold < 1 || effect > 4) begin
              $display("Stimulus file line %0d is malformed", line_no);
              ok = 1'b0;
            end else begin
              s.mic_rnd = (mic_str == "rnd");
              mic_val   = 128;
              if (!s.mic_rnd && $sscanf(mic_str, "%h", mic_val) != 1) begin
                $display("Stimulus file line %0d has a bad microphone sample", line_no);
                ok = 1'b0;
              end
              s.mic           = audio_sample_t'(mic_val);
              s.spk           = audio_sample_t'(spk);
              s.ptt           = ptt[0];
              s.ng            = ng[0];
              s.eff           = eff[0];
              s.mute          = mute[0];
              s.hold          = hold[15:0];
              s.exp_vol       = vol[0];
              s.exp_effect_en = een[0];
              s.exp_effect    = effect_sel_t'(effect[2:0]);
              steps.push_back(s);
              step_names.push_back(name);
            end
          end
        end
      end
      $fclose(fd);
      if (ok && steps.size() == 0) begin
        $display("The stimulus file holds no test steps");
        ok = 1'b0;
      end
    end
  endtask

  task automatic run_step(input int idx);
    step_t         s;
    audio_sample_t mic;
    int            errors_before;
    s             = steps[idx];
    errors_before = error_count;
    if (s.mic_rnd) begin
      mic = 8'd65 + 8'($urandom % 127); // 65 to 191, inside the gate band
    end else begin
      mic = s.mic;
    end
    @(posedge clk);
    mic_aud    <= mic;
    spk_aud    <= s.spk;
    ptt_en     <= s.ptt;
    ng_btn     <= s.ng;
    effect_btn <= s.eff;
    mute_btn   <= s.mute;
    repeat (s.hold) @(posedge clk);
    @(negedge clk); // Outputs settled mid cycle
    check_value(step_names[idx], "vol_en", 8'(s.exp_vol), 8'(vol_en));
    check_value(step_names[idx], "effect_en", 8'(s.exp_effect_en), 8'(effect_en));
    check_value(step_names[idx], "current_effect", 8'(s.exp_effect), 8'(current_effect));
    if (error_count == errors_before) begin
      tests_passed++;
      $display("Test %-16s passed", step_names[idx]);
    end else begin
      tests_failed++;
      $display("Test %-16s failed", step_names[idx]);
    end
  endtask

  initial begin : main
    int  total_hold;
    bit  load_ok;
    rst        = 1'b1;
    mic_aud    = audio_midpoint;
    spk_aud    = audio_midpoint;
    ptt_en     = 1'b0;
    ng_btn     = 1'b0;
    effect_btn = 1'b0;
    mute_btn   = 1'b0;
    void'($urandom(13)); // Only seeding of the run
    load_steps(load_ok);
    if (!load_ok) begin
      $display("Run stopped before any test, the stimulus could not be used");
      $display(">>> FAIL");
      $finish;
    end else begin
      total_hold = 0;
      foreach (steps[i]) begin
        total_hold += steps[i].hold;
      end
      watchdog_cycles = total_hold + 100;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      foreach (steps[i]) begin
        run_step(i);
      end
      $display("Tests run: %0d, passed: %0d, failed: %0d, mismatches: %0d",
               steps.size(), tests_passed, tests_failed, error_count);
      if (error_count == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

  initial begin : watchdog
    wait (watchdog_cycles > 0);
    #(watchdog_cycles * 40);
    $display("Timeout, the tests did not finish within %0d cycles", watchdog_cycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/intercom_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module intercom_ctrl
  import intercom_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  audio_sample_t mic_aud,        // Microphone stream
  input  audio_sample_t spk_aud,        // Speaker stream
  input  wire           ptt_en,         // Push-to-talk
  input  wire           ng_btn,         // Noise gate button
  input  wire           effect_btn,     // Effect button
  input  wire           mute_btn,       // Mute button
  output logic          vol_en,
  output logic          effect_en,
  output effect_sel_t   current_effect
);

  activity_t      activity;
  control_flags_t flags;

  audio_activity u_audio_activity (
    .clk      (clk),
    .rst      (rst),
    .mic_aud  (mic_aud),
    .spk_aud  (spk_aud),
    .activity (activity)
  );

  button_toggles u_button_toggles (
    .clk        (clk),
    .rst        (rst),
    .ng_btn     (ng_btn),
    .effect_btn (effect_btn),
    .mute_btn   (mute_btn),
    .spk_active (activity.spk_active), // Clears the gate toggle
    .flags      (flags)
  );

  talk_arbiter u_talk_arbiter (
    .clk       (clk),
    .rst       (rst),
    .ptt_en    (ptt_en),
    .flags     (flags),
    .activity  (activity),
    .vol_en    (vol_en),
    .effect_en (effect_en)
  );

  assign current_effect = flags.effect_sel;

endmodule

`default_nettype wire

//--- logic/talk_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module talk_arbiter
  import intercom_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            ptt_en,    // Push-to-talk level
  input  control_flags_t flags,
  input  activity_t      activity,
  output logic           vol_en,    // Speaker path enable
  output logic           effect_en  // Transmit effect enable
);

  link_state_t state;
  link_state_t state_next;
  hold_count_t hold_cnt;      // Quiet cycles while gated
  hold_count_t hold_cnt_next;
  logic        hold_done;     // This quiet cycle ends the hold

  assign hold_done = (hold_cnt == hold_count_t'(gate_hold_cycles - 1));

  always_comb begin
    state_next    = state;
    hold_cnt_next = '0;
    case (state)
      LIST: begin
        if (activity.spk_active) begin
          state_next = LIST; // Receive has priority
        end else if (ptt_en || (flags.gate_on && activity.voice_detected)) begin
          state_next = TALK;
        end
      end
      TALK: begin
        if (activity.spk_active) begin
          state_next = LIST;
        end else if (ptt_en) begin
          state_next = TALK;
        end else if (flags.gate_on) begin
          if (activity.voice_detected) begin
            hold_cnt_next = '0; // Voice restarts the hold
          end else if (hold_done) begin
            state_next = LIST;
          end else begin
            hold_cnt_next = hold_cnt + 1'b1;
          end
        end else begin
          state_next = LIST; // Nothing keeps the link open
        end
      end
      default: begin
        state_next = LIST;
      end
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state    <= LIST;
      hold_cnt <= '0;
    end else begin
      state    <= state_next;
      hold_cnt <= hold_cnt_next;
    end
  end

  // Moore outputs
  always_comb begin
    vol_en    = 1'b0;
    effect_en = 1'b0;
    case (state)
      LIST: begin
        vol_en = ~flags.mute_on;
      end
      TALK: begin
        effect_en = 1'b1;
      end
      default: begin
        vol_en    = 1'b0;
        effect_en = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/button_toggles.sv
`timescale 1ns/10ps
`default_nettype none

module button_toggles
  import intercom_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            ng_btn,     // Noise gate button
  input  wire            effect_btn, // Effect step button
  input  wire            mute_btn,   // Mute button
  input  wire            spk_active, // Far end talking
  output control_flags_t flags
);

  // Bit 2 noise gate, bit 1 effect, bit 0 mute
  logic [2:0] btn_new;    // Newer register stage
  logic [2:0] btn_old;    // Older register stage
  logic [2:0] btn_rise;   // Newer high, older low
  logic [2:0] press_q;    // One pulse per press

  logic ng_press;
  logic effect_press;
  logic mute_press;

  logic        mute_q;
  logic        gate_q;
  effect_sel_t effect_q;
  effect_sel_t effect_next;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      btn_new <= '0;
      btn_old <= '0;
      press_q <= '0;
    end else begin
      btn_new <= {ng_btn, effect_btn, mute_btn};
      btn_old <= btn_new;
      press_q <= btn_rise; // Takes effect one edge later
    end
  end

  assign btn_rise = btn_new & ~btn_old;

  assign ng_press     = press_q[2];
  assign effect_press = press_q[1];
  assign mute_press   = press_q[0];

  // Mute and gate toggles
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      mute_q <= 1'b0;
      gate_q <= 1'b0;
    end else begin
      if (mute_press) begin
        mute_q <= ~mute_q;
      end
      if (spk_active) begin
        gate_q <= 1'b0; // Far end speech wins over the gate
      end else if (ng_press) begin
        gate_q <= ~gate_q;
      end
    end
  end

  // Effect selection walks the list and wraps
  always_comb begin
    effect_next = effect_q;
    if (effect_press) begin
      case (effect_q)
        NORMAL:  effect_next = ECHO;
        ECHO:    effect_next = TREMOLO;
        TREMOLO: effect_next = REVERB;
        REVERB:  effect_next = SOFT;
        SOFT:    effect_next = NORMAL;
        default: effect_next = NORMAL;
      endcase
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      effect_q <= NORMAL;
    end else begin
      effect_q <= effect_next;
    end
  end

  assign flags = '{
    mute_on:    mute_q,
    gate_on:    gate_q,
    effect_sel: effect_q
  };

endmodule

`default_nettype wire

//--- logic/audio_activity.sv
`timescale 1ns/10ps
`default_nettype none

module audio_activity
  import intercom_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  audio_sample_t mic_aud,  // Transmit side sample
  input  audio_sample_t spk_aud,  // Receive side sample
  output activity_t     activity
);

  logic voice_next;   // Mic level beyond the band this cycle
  logic voice_q;      // Registered voice flag
  logic spk_active;   // Speaker carries audio

  // Voice lies outside the band around the midpoint, on either side
  always_comb begin
    if (mic_aud >= audio_midpoint) begin
      voice_next = (mic_aud >= audio_midpoint + gate_threshold); // 192 and up
    end else begin
      voice_next = (mic_aud <= audio_midpoint - gate_threshold); // 64 and down
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      voice_q <= 1'b0;
    end else begin
      voice_q <= voice_next;
    end
  end

  // Any sample off the midpoint means the far end is speaking
  assign spk_active = (spk_aud != audio_midpoint);

  assign activity = '{
    voice_detected: voice_q,
    spk_active:     spk_active
  };

endmodule

`default_nettype wire

//--- logic/intercom_pkg.sv
`default_nettype none

package intercom_pkg;

  // Offset-binary audio, 128 is silence
  typedef logic [7:0] audio_sample_t;

  localparam audio_sample_t audio_midpoint = 8'd128; // Silence level
  localparam audio_sample_t gate_threshold = 8'd64;  // Voice distance from midpoint

  // Selected transmit effect, cycled by the effect button
  typedef enum logic [2:0] {
    NORMAL  = 3'd0,
    ECHO    = 3'd1,
    TREMOLO = 3'd2,
    REVERB  = 3'd3,
    SOFT    = 3'd4
  } effect_sel_t;

  // Link direction of the unit
  typedef enum logic {
    LIST = 1'b0, // Speaker path open
    TALK = 1'b1  // Microphone path open
  } link_state_t;

  localparam int gate_hold_cycles = 16; // Quiet cycles before a gated talk ends

  typedef logic [4:0] hold_count_t; // Counts up to gate_hold_cycles

  // User settings kept by the button block
  typedef struct packed {
    logic        mute_on;    // Speaker muted
    logic        gate_on;    // Voice-operated talk enabled
    effect_sel_t effect_sel; // Current effect
  } control_flags_t;

  // Audio level judgements
  typedef struct packed {
    logic voice_detected; // Mic beyond gate threshold, registered
    logic spk_active;     // Speaker not silent, combinational
  } activity_t;

endpackage

`default_nettype wire
